/* src/ttag_pkg.sv */
package ttag_pkg;

  // fetch address.
  typedef logic [43:0] ip_t;

  // set index, taken from ip bits 13..7.
  typedef logic [6:0] set_t;

  typedef logic [5:0] len_t; // fetch-block length.

  typedef logic [1:0] way_t;

  // one stored tag entry.
  typedef logic [43:0] entry_t;

  localparam int set_count = 128;

  localparam int set_lo = 7; // lowest index bit of ip.

  // first ip bit of the high tag, just above the index.
  localparam int tag_lo = set_lo + $bits(set_t);

  // entry field positions.
  localparam int entry_valid = 43;

  localparam int entry_len_hi = 42;
  localparam int entry_len_lo = 37;

  localparam int entry_iph_hi = 36; // ip bits 43..14.
  localparam int entry_iph_lo = 7;

  localparam int entry_ipl_hi = 6; // ip bits 6..0.
  localparam int entry_ipl_lo = 0;

endpackage

/* src/ttag_write_if.sv */
`timescale 1ns/10ps

interface ttag_write_if;
  import ttag_pkg::*;

  logic   wen;
  logic   all_ways; // flush broadcast.
  way_t   sel_way;
  set_t   index;
  entry_t entry;

  // driven by the write controller.
  modport ctl (
    output wen,
    output all_ways,
    output sel_way,
    output index,
    output entry
  );

  modport way (
    input wen,
    input all_ways,
    input sel_way,
    input index,
    input entry
  );

endinterface

/* src/ttag_ram.sv */
`timescale 1ns/10ps

module ttag_ram (
  input  logic              clk,
  input  logic              rd_en,
  input  ttag_pkg::set_t    rd_index,
  output ttag_pkg::entry_t  rd_data,
  input  logic              wr_en,
  input  ttag_pkg::set_t    wr_index,
  input  ttag_pkg::entry_t  wr_data
);
  import ttag_pkg::*;

  entry_t mem [set_count];

  // registered read, old data on a same-set write.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_index];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
  end

endmodule

/* src/ttag_way.sv */
`timescale 1ns/10ps

module ttag_way #(
  parameter int way_id = 0
) (
  input  logic           clk,
  input  logic           rd_en,
  input  ttag_pkg::ip_t  rd_ip,
  input  ttag_pkg::ip_t  rd_ip_q,
  ttag_write_if.way      wr,
  output logic           hit,
  output ttag_pkg::ip_t  next_ip
);
  import ttag_pkg::*;

  localparam int ip_bits   = $bits(ip_t);
  localparam int len_bits  = $bits(len_t);
  localparam int high_bits = ip_bits - len_bits;

  logic                 wr_en;
  entry_t               rd_data;
  logic                 low_eq;
  logic                 high_eq;
  logic [len_bits:0]    low_sum;
  logic [high_bits-1:0] high_sum;

  // own way, or every way during a flush.
  assign wr_en = wr.wen && (wr.all_ways || wr.sel_way == way_t'(way_id));

  ttag_ram i_ram (
    .clk      (clk),
    .rd_en    (rd_en),
    .rd_index (rd_ip[tag_lo-1:set_lo]),
    .rd_data  (rd_data),
    .wr_en    (wr_en),
    .wr_index (wr.index),
    .wr_data  (wr.entry)
  );

  // index bits are implied by the set.
  assign low_eq  = rd_data[entry_ipl_hi:entry_ipl_lo] == rd_ip_q[set_lo-1:0];
  assign high_eq = rd_data[entry_iph_hi:entry_iph_lo] == rd_ip_q[ip_bits-1:tag_lo];

  assign hit = rd_data[entry_valid] && low_eq && high_eq;

  // low add, one bit wider for the carry.
  assign low_sum = {1'b0, rd_ip_q[len_bits-1:0]} +
                   {1'b0, rd_data[entry_len_hi:entry_len_lo]};

  // carry runs through bits 43..6.
  assign high_sum = rd_ip_q[ip_bits-1:len_bits] + high_bits'(low_sum[len_bits]);

  // zero on a miss so the parent can OR.
  assign next_ip = hit ? {high_sum, low_sum[len_bits-1:0]} : '0;

endmodule

/* src/ttag_write_ctl.sv */
`timescale 1ns/10ps

module ttag_write_ctl #(
  parameter int way_count = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            write_en,
  input  ttag_pkg::ip_t   write_ip,
  input  ttag_pkg::len_t  write_len,
  input  ttag_pkg::way_t  write_way,
  input  logic            flush,
  output logic            stall,
  ttag_write_if.ctl       wr
);
  import ttag_pkg::*;

  typedef enum logic {
    idle,
    walk
  } state_t;

  state_t state;
  logic   init_pend; // walk still owed after reset.
  logic   walk_start;
  logic   way_ok;
  logic   last_set;
  entry_t new_entry;

  assign walk_start = flush || init_pend;
  assign way_ok     = int'(write_way) < way_count; // out of range ways are dropped.
  assign last_set   = wr.index == set_t'(set_count - 1);

  always_comb begin
    new_entry = '0;
    new_entry[entry_valid] = 1'b1;
    new_entry[entry_len_hi:entry_len_lo] = write_len;
    new_entry[entry_iph_hi:entry_iph_lo] = write_ip[$bits(ip_t)-1:tag_lo];
    new_entry[entry_ipl_hi:entry_ipl_lo] = write_ip[set_lo-1:0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= idle;
      init_pend   <= 1'b1;
      wr.wen      <= 1'b0;
      wr.all_ways <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (walk_start) begin
            state       <= walk;
            init_pend   <= 1'b0;
            wr.wen      <= 1'b1;
            wr.all_ways <= 1'b1;
          end else begin
            wr.wen      <= write_en && way_ok;
            wr.all_ways <= 1'b0;
          end
        end
        walk: begin
          if (last_set) begin // set 127 goes out this edge.
            state       <= idle;
            wr.wen      <= 1'b0;
            wr.all_ways <= 1'b0;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // bus payload, the index doubles as the walk counter.
  always_ff @(posedge clk) begin
    if (state == walk) begin
      wr.index <= wr.index + set_t'(1);
    end else if (walk_start) begin
      wr.index <= '0;
      wr.entry <= '0; // invalid entry.
    end else if (write_en) begin
      wr.index   <= write_ip[tag_lo-1:set_lo];
      wr.entry   <= new_entry;
      wr.sel_way <= write_way;
    end
  end

  assign stall = state == walk;

endmodule

/* src/ttag.sv */
`timescale 1ns/10ps

module ttag #(
  parameter int way_count = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            read_en,
  input  ttag_pkg::ip_t   read_ip,
  output logic [3:0]      hit,
  output ttag_pkg::ip_t   next_ip,
  input  logic            write_en,
  input  ttag_pkg::ip_t   write_ip,
  input  ttag_pkg::len_t  write_len,
  input  ttag_pkg::way_t  write_way,
  input  logic            flush,
  output logic            stall
);
  import ttag_pkg::*;

  localparam int max_ways = 4; // width of the hit vector.

  logic              rd_en;
  logic              rd_vld; // a lookup has been accepted since reset.
  ip_t               rd_ip_q;
  logic [max_ways-1:0] way_hit;
  ip_t               way_next [max_ways];
  ip_t               next_or;

  ttag_write_if wr_bus ();

  // no lookups during the flush walk.
  assign rd_en = read_en && !stall;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ip_q <= '0;
      rd_vld  <= 1'b0;
    end else if (rd_en) begin
      rd_ip_q <= read_ip;
      rd_vld  <= 1'b1;
    end
  end

  ttag_write_ctl #(
    .way_count (way_count)
  ) i_write_ctl (
    .clk       (clk),
    .rst       (rst),
    .write_en  (write_en),
    .write_ip  (write_ip),
    .write_len (write_len),
    .write_way (write_way),
    .flush     (flush),
    .stall     (stall),
    .wr        (wr_bus)
  );

  for (genvar w = 0; w < max_ways; w++) begin : g_way
    if (w < way_count) begin : g_used
      ttag_way #(
        .way_id (w)
      ) i_way (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_ip   (read_ip),
        .rd_ip_q (rd_ip_q),
        .wr      (wr_bus),
        .hit     (way_hit[w]),
        .next_ip (way_next[w])
      );
    end else begin : g_unused
      assign way_hit[w]  = 1'b0;
      assign way_next[w] = '0;
    end
  end

  // missing ways give zero.
  always_comb begin
    next_or = '0;
    for (int i = 0; i < max_ways; i++) begin
      next_or = next_or | way_next[i];
    end
  end

  // ram output is unknown until the first lookup.
  assign hit     = rd_vld ? way_hit : '0;
  assign next_ip = rd_vld ? next_or : '0;

endmodule

/* testbench/tb_ttag.sv */
`timescale 1ns/10ps

module tb_ttag;
  import ttag_pkg::*;

  logic       clk;
  logic       rst;
  logic       read_en;
  ip_t        read_ip;
  logic [3:0] hit;
  ip_t        next_ip;
  logic       write_en;
  ip_t        write_ip;
  len_t       write_len;
  way_t       write_way;
  logic       flush;
  logic       stall;

  // one entry per operation line of the stimulus file.
  logic [7:0]      op_q    [$];
  logic [8*24-1:0] name_q  [$];
  logic [43:0]     arg_a_q [$];
  logic [43:0]     arg_b_q [$];
  logic [43:0]     arg_c_q [$];

  int line_count;
  int flush_count;
  int cycle_limit;
  int cycles;

  ttag #(
    .way_count (4)
  ) i_ttag (
    .clk       (clk),
    .rst       (rst),
    .read_en   (read_en),
    .read_ip   (read_ip),
    .hit       (hit),
    .next_ip   (next_ip),
    .write_en  (write_en),
    .write_ip  (write_ip),
    .write_len (write_len),
    .write_way (write_way),
    .flush     (flush),
    .stall     (stall)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the stimulus did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check(input logic [8*24-1:0] tname, input string what,
                       input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in test %0s, %s expected %h actual %h",
               tname, what, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  task automatic load_stim();
    int              fd;
    int              code;
    logic            args_ok;
    logic [7:0]      op;
    logic [8*24-1:0] name;
    logic [43:0]     a;
    logic [43:0]     b;
    logic [43:0]     c;
    logic [8*128-1:0] rest;
    fd = $fopen("testbench/ttag_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file testbench/ttag_stim.txt");
      $display("RESULT: FAIL");
      $fatal(1, "no stimulus");
    end
    line_count  = 0;
    flush_count = 0;
    while ($fscanf(fd, " %c", op) == 1) begin
      line_count++;
      a = '0;
      b = '0;
      c = '0;
      if (op == "#") begin
        code = $fgets(rest, fd); // rest of a comment line.
      end else begin
        code = $fscanf(fd, "%s", name);
        args_ok = code == 1;
        case (op)
          "W", "R": args_ok = args_ok && ($fscanf(fd, "%h %h %h", a, b, c) == 3);
          "S": args_ok = args_ok && ($fscanf(fd, "%d", a) == 1);
          "F": flush_count++;
          default: args_ok = 1'b0;
        endcase
        if (!args_ok) begin
          $display("stimulus line %0d is not a valid operation", line_count);
          $display("RESULT: FAIL");
          $fatal(1, "bad stimulus");
        end
        op_q.push_back(op);
        name_q.push_back(name);
        arg_a_q.push_back(a);
        arg_b_q.push_back(b);
        arg_c_q.push_back(c);
      end
    end
    $fclose(fd);
  endtask

  // one write request, then two idle cycles.
  task automatic write_entry(input ip_t ip, input len_t len, input way_t way);
    write_en  = 1'b1;
    write_ip  = ip;
    write_len = len;
    write_way = way;
    @(negedge clk);
    write_en = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic lookup(input logic [8*24-1:0] tname, input ip_t ip,
                        input logic [3:0] exp_hit, input ip_t exp_next);
    read_en = 1'b1;
    read_ip = ip;
    @(negedge clk);
    read_en = 1'b0; // results are valid one edge later.
    check(tname, "hit", 64'(exp_hit), 64'(hit));
    check(tname, "next_ip", 64'(exp_next), 64'(next_ip));
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
  endtask

  task automatic count_stall(input logic [8*24-1:0] tname, input int expected);
    int n;
    n = 0;
    while (stall) begin
      n++;
      @(negedge clk);
    end
    check(tname, "stall cycles", 64'(expected), 64'(n));
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    read_en     = 1'b0;
    read_ip     = '0;
    write_en    = 1'b0;
    write_ip    = '0;
    write_len   = '0;
    write_way   = '0;
    flush       = 1'b0;
    cycles      = 0;
    cycle_limit = 0;
    load_stim();
    cycle_limit = 200 + 4 * line_count + 130 * flush_count;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk); // the reset walk has started here.
    // no lookup yet, so both results read as zero.
    check("after_reset", "hit", 64'h0, 64'(hit));
    check("after_reset", "next_ip", 64'h0, 64'(next_ip));
    for (int i = 0; i < op_q.size(); i++) begin
      case (op_q[i])
        "W": write_entry(ip_t'(arg_a_q[i]), len_t'(arg_b_q[i]), way_t'(arg_c_q[i]));
        "R": lookup(name_q[i], ip_t'(arg_a_q[i]), 4'(arg_b_q[i]), ip_t'(arg_c_q[i]));
        "F": pulse_flush();
        "S": count_stall(name_q[i], int'(arg_a_q[i]));
        default: ;
      endcase
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* testbench/ttag_stim.txt */
# op name then args, values in hex except the S cycle count
# W ip len way | R ip exp_hit exp_next | F | S cycles
S reset_walk 128
R reset_miss_a 00000000000 0 00000000000
R reset_miss_b 00048D14290 0 00000000000
R reset_miss_c FFFFFFFFFFA 0 00000000000
# one entry per way
W inst_w0 00048D14290 08 0
R hit_w0 00048D14290 1 00048D14298
W inst_w1 00002AF02A3 11 1
R hit_w1 00002AF02A3 2 00002AF02B4
R hit_w0_again 00048D14290 1 00048D14298
# carry out of bit 5 wraps the whole address
W inst_w2 FFFFFFFFFFA 06 2
R wrap_w2 FFFFFFFFFFA 4 00000000000
W inst_w3 0003C3C10BC 0A 3
R carry_w3 0003C3C10BC 8 0003C3C10C6
# carry through the index into the high tag
W inst_w3_far 00000007FFE 3F 3
R carry_far_w3 00000007FFE 8 0000000803D
R carry_w3_kept 0003C3C10BC 8 0003C3C10C6
R wrap_w2_kept FFFFFFFFFFA 4 00000000000
# zero length gives the same address
W inst_zero_len 00000002015 00 1
R zero_len 00000002015 2 00000002015
# same set with another tag, and sets never written
R miss_high 00048D18290 0 00000000000
R miss_low 00048D14291 0 00000000000
R miss_set_a 00000005000 0 00000000000
R miss_set_b 00000000C00 0 00000000000
R miss_far_high FFFFFFFFFFE 0 00000000000
# a third way at set 5, each entry hits only its own way
W inst_w2_set5 00048D142C4 3F 2
R hit_w2_set5 00048D142C4 4 00048D14303
R hit_w0_set5 00048D14290 1 00048D14298
R hit_w1_set5 00002AF02A3 2 00002AF02B4
R wrap_w2_set7f FFFFFFFFFFA 4 00000000000
# flush clears every way
F flush_all
S flush_walk 128
R flushed_w0 00048D14290 0 00000000000
R flushed_w1 00002AF02A3 0 00000000000
R flushed_w2 FFFFFFFFFFA 0 00000000000
R flushed_w3 0003C3C10BC 0 00000000000
R flushed_far 00000007FFE 0 00000000000
R flushed_set5 00048D142C4 0 00000000000
R flushed_zero 00000002015 0 00000000000
# new entries after the flush
W reinst_w1 00048D14290 08 1
R reinst_w1_hit 00048D14290 2 00048D14298
W reinst_w3 FFFFFFFFFFA 06 3
R reinst_w3_hit FFFFFFFFFFA 8 00000000000
# write during the walk is dropped, 3 stall cycles pass inside W
F flush_drop
W drop_w0 00002AF02A3 11 0
S drop_walk 125
R drop_miss 00002AF02A3 0 00000000000
R drop_flushed_w1 00048D14290 0 00000000000
R drop_flushed_w3 FFFFFFFFFFA 0 00000000000
W after_drop 00002AF02A3 11 0
R after_drop_hit 00002AF02A3 1 00002AF02B4
W after_drop_w2 0003C3C10BC 0A 2
R after_drop_w2_hit 0003C3C10BC 4 0003C3C10C6
R after_drop_w0_kept 00002AF02A3 1 00002AF02B4

/* list.f */
src/ttag_pkg.sv
src/ttag_write_if.sv
src/ttag_ram.sv
src/ttag_way.sv
src/ttag_write_ctl.sv
src/ttag.sv
testbench/tb_ttag.sv

/* run.sh */
#!/bin/sh
# build and run the ttag testbench with verilator, log in sim.log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/10ps --top-module tb_ttag \
  -f list.f -o tb_ttag > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_ttag > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
